/* sources.f */
+incdir+common
common/armDpPkg.sv
regFile/regFile.sv
hw/immRotator.sv
alu/executeUnit.sv
hw/armDpCore.sv
tests/armDp_checker.sv
tests/armDpTb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module armDpTb -f sources.f -o armDpSim \
  && ./obj_dir/armDpSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tests/armDpTb.sv */
`timescale 1ns/1ps
`include "armDp_defines.svh"

module armDpTb;

  import armDpPkg::*;

  typedef struct packed {
    aluOp_e  op;
    logic    wrote;
    regIdx_t rd;
    word_t   data;
    nzcv_s   flags;
  } expect_s;

  logic       clk;
  logic       rstN;
  logic       instrValid;
  dpInstr_u   instr;
  logic       resultValid;
  dpResult_s  result;
  nzcv_s      flags;

  word_t      modelRegs [`ARMDP_REG_CNT];
  nzcv_s      modelFlags;
  expect_s    expQ [$];
  expect_s    got;
  int         errors;
  int         checks;
  int         timeouts;
  integer     seed;
  word_t      rnd;

  armDpCore dut0 (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result),
    .flags       (flags)
  );

  bind armDpCore armDpChecker checker0 (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result),
    .flags       (flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic word_t rotateRight(input word_t x, input int amt);
    word_t r;
    begin
      r = x;
      for (int i = 0; i < amt; i++)
      begin
        r = {r[0], r[`ARMDP_DATA_W-1:1]};
      end
      return r;
    end
  endfunction

  function automatic dpInstr_u immInstr(input aluOp_e op, input logic s, input regIdx_t rn,
                                        input regIdx_t rd, input logic [3:0] rot,
                                        input logic [7:0] imm8);
    dpInstr_u ins;
    begin
      ins.immForm = '{cond: 4'he, cls: 2'b00, immSel: 1'b1, opcode: op, setFlags: s,
                      rn: rn, rd: rd, rotate: rot, imm8: imm8};
      return ins;
    end
  endfunction

  function automatic dpInstr_u regInstr(input aluOp_e op, input logic s, input regIdx_t rn,
                                        input regIdx_t rd, input regIdx_t rm);
    dpInstr_u ins;
    begin
      ins.regForm = '{cond: 4'he, cls: 2'b00, immSel: 1'b0, opcode: op, setFlags: s,
                      rn: rn, rd: rd, shiftField: 8'h00, rm: rm};
      return ins;
    end
  endfunction

  // Subtraction borrows the inverse of the carry-in
  task automatic arithModel(input word_t x, input word_t y, input logic ci, input logic sub,
                            output word_t value, output logic c, output logic v);
    longint sRes;
    begin
      if (sub)
      begin
        value = x - y - word_t'(!ci);
        c = ({1'b0, x} >= ({1'b0, y} + {1'b0, word_t'(!ci)}));
        sRes = longint'($signed(x)) - longint'($signed(y)) - longint'(!ci);
      end
      else
      begin
        {c, value} = {1'b0, x} + {1'b0, y} + {1'b0, word_t'(ci)};
        sRes = longint'($signed(x)) + longint'($signed(y)) + longint'(ci);
      end
      v = (sRes > 64'sd2147483647) || (sRes < -64'sd2147483648);
    end
  endtask

  task automatic modelStep(input dpInstr_u ins);
    expect_s e;
    word_t   a;
    word_t   b;
    word_t   value;
    logic    c;
    logic    v;
    logic    arith;
    begin
      e.op = ins.immForm.opcode;
      a = modelRegs[ins.immForm.rn];
      if (ins.immForm.immSel)
      begin
        b = rotateRight({24'h0, ins.immForm.imm8}, int'(ins.immForm.rotate) * 2);
      end
      else
      begin
        b = modelRegs[ins.regForm.rm];
      end
      arith = 1'b1;
      c = modelFlags.c;
      v = modelFlags.v;
      value = '0;
      case (e.op)
        opAdd, opCmn: arithModel(a, b, 1'b0, 1'b0, value, c, v);
        opAdc:        arithModel(a, b, modelFlags.c, 1'b0, value, c, v);
        opSub, opCmp: arithModel(a, b, 1'b1, 1'b1, value, c, v);
        opSbc:        arithModel(a, b, modelFlags.c, 1'b1, value, c, v);
        opRsb:        arithModel(b, a, 1'b1, 1'b1, value, c, v);
        opRsc:        arithModel(b, a, modelFlags.c, 1'b1, value, c, v);
        default:      arith = 1'b0;
      endcase
      case (e.op)
        opAnd, opTst: value = a & b;
        opEor, opTeq: value = a ^ b;
        opOrr:        value = a | b;
        opMov:        value = b;
        opBic:        value = a & ~b;
        opMvn:        value = ~b;
        default:      value = value;
      endcase
      if (ins.immForm.setFlags)
      begin
        modelFlags = '{n: value[`ARMDP_DATA_W-1], z: (value == '0), c: c, v: v};
      end
      e.wrote = !(e.op inside {opTst, opTeq, opCmp, opCmn});
      if (e.wrote)
      begin
        modelRegs[ins.immForm.rd] = value;
      end
      e.rd = ins.immForm.rd;
      e.data = value;
      e.flags = modelFlags;
      expQ.push_back(e);
    end
  endtask

  task automatic issue(input dpInstr_u ins);
    begin
      modelStep(ins);
      instr = ins;
      instrValid = 1'b1;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic waitResults(input int limit);
    int waited;
    begin
      instrValid = 1'b0;
      waited = 0;
      while (expQ.size() != 0 && waited < limit)
      begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (expQ.size() != 0)
      begin
        $display("Timeout after %0d cycles with %0d results never seen", limit, expQ.size());
        timeouts++;
        expQ.delete();
      end
    end
  endtask

  task automatic single(input dpInstr_u ins);
    begin
      issue(ins);
      waitResults(10);
    end
  endtask

  // Registered outputs are settled by the falling edge
  always @(negedge clk)
  begin
    if (resultValid)
    begin
      if (expQ.size() == 0)
      begin
        $display("Unexpected resultValid at time %0t with no instruction pending", $time);
        errors++;
      end
      else
      begin
        got = expQ.pop_front();
        checks++;
        assert (result.data == got.data && result.rd == got.rd)
        else
        begin
          $display("FAIL %0t: r%0d %s expected %h actual r%0d %h", $time, got.rd,
                   got.op.name(), got.data, result.rd, result.data);
          errors++;
        end
        assert (result.wrote == got.wrote)
        else
        begin
          $display("FAIL %0t: r%0d %s wrote expected %b actual %b", $time, got.rd,
                   got.op.name(), got.wrote, result.wrote);
          errors++;
        end
        assert (flags == got.flags)
        else
        begin
          $display("FAIL %0t: r%0d %s NZCV expected %b actual %b", $time, got.rd,
                   got.op.name(), got.flags, flags);
          errors++;
        end
      end
    end
  end

  initial
  begin
    seed = 32'hd60e;
    errors = 0;
    checks = 0;
    timeouts = 0;
    modelFlags = '0;
    for (int i = 0; i < `ARMDP_REG_CNT; i++)
    begin
      modelRegs[i] = '0;
    end
    // A strobe held through reset must leave no trace
    rstN = 1'b0;
    instrValid = 1'b1;
    instr = immInstr(opMvn, 1'b1, 4'd0, 4'd1, 4'd0, 8'h00);
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;
    instrValid = 1'b0;

    // Reset state
    assert (!resultValid && !result.wrote && flags == '0)
    else
    begin
      $display("FAIL %0t: reset state resultValid %b wrote %b flags %b", $time,
               resultValid, result.wrote, flags);
      errors++;
    end
    repeat (3) @(posedge clk);
    #1;
    single(regInstr(opAdd, 1'b0, 4'd1, 4'd3, 4'd2));

    // Immediate loads over several rotations
    single(immInstr(opMov, 1'b0, 4'd0, 4'd1, 4'd0, 8'h5a));
    single(immInstr(opMov, 1'b1, 4'd0, 4'd2, 4'd1, 8'h03));
    single(immInstr(opMov, 1'b0, 4'd0, 4'd3, 4'd4, 8'hc3));
    single(immInstr(opMov, 1'b0, 4'd0, 4'd4, 4'd8, 8'hff));
    single(immInstr(opMov, 1'b1, 4'd0, 4'd5, 4'd15, 8'h81));
    single(immInstr(opMvn, 1'b0, 4'd0, 4'd6, 4'd0, 8'h00));
    single(immInstr(opMov, 1'b0, 4'd0, 4'd7, 4'd0, 8'h01));
    single(immInstr(opMvn, 1'b0, 4'd0, 4'd8, 4'd1, 8'h02));
    single(immInstr(opMov, 1'b0, 4'd0, 4'd11, 4'd1, 8'h02));

    // Arithmetic with carry, borrow and overflow
    single(regInstr(opAdd, 1'b1, 4'd6, 4'd9, 4'd7));
    single(regInstr(opAdc, 1'b1, 4'd7, 4'd9, 4'd7));
    single(regInstr(opAdd, 1'b1, 4'd8, 4'd9, 4'd7));
    single(regInstr(opSub, 1'b1, 4'd7, 4'd10, 4'd6));
    single(regInstr(opSbc, 1'b1, 4'd8, 4'd10, 4'd7));
    single(regInstr(opRsb, 1'b1, 4'd7, 4'd10, 4'd11));
    single(regInstr(opRsc, 1'b1, 4'd6, 4'd10, 4'd7));
    single(regInstr(opSub, 1'b1, 4'd7, 4'd10, 4'd7));

    // C and V set first and then kept by logical ops
    single(regInstr(opAdd, 1'b1, 4'd11, 4'd12, 4'd11));
    single(regInstr(opAnd, 1'b1, 4'd6, 4'd12, 4'd8));
    single(regInstr(opEor, 1'b1, 4'd6, 4'd12, 4'd7));
    single(regInstr(opOrr, 1'b1, 4'd11, 4'd12, 4'd7));
    single(regInstr(opBic, 1'b1, 4'd6, 4'd12, 4'd6));
    single(regInstr(opMvn, 1'b1, 4'd0, 4'd12, 4'd8));

    // Test opcodes target r5 and a later MOV reads it back
    single(regInstr(opTst, 1'b1, 4'd6, 4'd5, 4'd11));
    single(regInstr(opTeq, 1'b1, 4'd6, 4'd5, 4'd6));
    single(regInstr(opCmp, 1'b1, 4'd7, 4'd5, 4'd6));
    single(regInstr(opCmn, 1'b1, 4'd6, 4'd5, 4'd7));
    single(regInstr(opMov, 1'b0, 4'd0, 4'd13, 4'd5));

    // Back-to-back random mix
    for (int i = 0; i < 200; i++)
    begin
      rnd = $random(seed);
      if (rnd[29])
      begin
        issue(immInstr(aluOp_e'(rnd[3:0]), rnd[4], rnd[8:5], rnd[12:9], rnd[20:17],
                       rnd[28:21]));
      end
      else
      begin
        issue(regInstr(aluOp_e'(rnd[3:0]), rnd[4], rnd[8:5], rnd[12:9], rnd[16:13]));
      end
    end
    waitResults(20);

    $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tests/armDp_checker.sv */
`timescale 1ns/1ps

module armDpChecker (
  input logic                clk,
  input logic                rstN,
  input logic                instrValid,
  input armDpPkg::dpInstr_u  instr,
  input logic                resultValid,
  input armDpPkg::dpResult_s result,
  input armDpPkg::nzcv_s     flags
);

  import armDpPkg::*;

  logic isTestOp;
  logic keepFlags;

  assign isTestOp  = instr.immForm.opcode inside {opTst, opTeq, opCmp, opCmn};
  assign keepFlags = instrValid && !instr.immForm.setFlags;

  // One-cycle latency
  validFollows: assert property (
    @(posedge clk) disable iff (!rstN)
    instrValid |=> resultValid
  )
  else
    $error("resultValid did not follow instrValid by one cycle");

  // No pulse without a strobe
  validOnlyAfterStrobe: assert property (
    @(posedge clk) disable iff (!rstN)
    !instrValid |=> !resultValid
  )
  else
    $error("resultValid high without a strobe one cycle earlier");

  flagsHeld: assert property (
    @(posedge clk) disable iff (!rstN)
    keepFlags |=> $stable(flags)
  )
  else
    $error("Flags changed after an instruction with setFlags low");

  // Test and compare opcodes never write back
  noWriteOnTest: assert property (
    @(posedge clk) disable iff (!rstN)
    (instrValid && isTestOp) |=> !result.wrote
  )
  else
    $error("result.wrote high for a test or compare opcode");

  validLowInReset: assert property (
    @(posedge clk)
    !rstN |=> !resultValid
  )
  else
    $error("resultValid high during reset");

endmodule

/* hw/armDpCore.sv */
`timescale 1ns/1ps

module armDpCore (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 instrValid,
  input  armDpPkg::dpInstr_u   instr,
  output logic                 resultValid,
  output armDpPkg::dpResult_s  result,
  output armDpPkg::nzcv_s      flags
);

  import armDpPkg::*;

  word_t    rnData;
  word_t    rmData;
  word_t    immOperand;
  rfWrite_s rfWrite;

  // Operand fetch, register side
  regFile regFile0 (
    .clk    (clk),
    .rstN   (rstN),
    .rnAddr (instr.regForm.rn),
    .rmAddr (instr.regForm.rm),
    .write  (rfWrite),
    .rnData (rnData),
    .rmData (rmData)
  );

  // Operand fetch, immediate side
  immRotator immRotator0 (
    .rotate     (instr.immForm.rotate),
    .imm8       (instr.immForm.imm8),
    .immOperand (immOperand)
  );

  executeUnit executeUnit0 (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .rnData      (rnData),
    .rmData      (rmData),
    .immOperand  (immOperand),
    .rfWrite     (rfWrite),
    .resultValid (resultValid),
    .result      (result),
    .flags       (flags)
  );

endmodule

/* alu/executeUnit.sv */
`timescale 1ns/1ps
`include "armDp_defines.svh"

module executeUnit (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 instrValid,
  input  armDpPkg::dpInstr_u   instr,
  input  armDpPkg::word_t      rnData,
  input  armDpPkg::word_t      rmData,
  input  armDpPkg::word_t      immOperand,
  output armDpPkg::rfWrite_s   rfWrite,
  output logic                 resultValid,
  output armDpPkg::dpResult_s  result,
  output armDpPkg::nzcv_s      flags
);

  import armDpPkg::*;

  localparam int Msb = `ARMDP_DATA_W - 1;

  aluOp_e  opcode;
  regIdx_t rd;
  word_t   opB;
  word_t   addA;
  word_t   addB;
  logic    addCin;
  logic    isArith;
  logic    isTest;
  word_t   logicValue;
  word_t   aluValue;
  logic [`ARMDP_DATA_W:0] sum;
  logic    carryOut;
  logic    overflow;
  nzcv_s   flagsQ;
  nzcv_s   flagsNext;
  logic    validQ;
  logic    wroteQ;
  regIdx_t rdQ;
  word_t   dataQ;

  // Leading fields sit at the same place in both forms
  assign opcode = instr.immForm.opcode;
  assign rd     = instr.immForm.rd;
  assign opB    = instr.immForm.immSel ? immOperand : rmData;

  // Subtractions go through the adder as A + ~B + cin
  always_comb
  begin
    addA       = '0;
    addB       = '0;
    addCin     = 1'b0;
    isArith    = 1'b0;
    logicValue = '0;
    unique case (opcode)
      opAnd, opTst: logicValue = rnData & opB;
      opEor, opTeq: logicValue = rnData ^ opB;
      opOrr:        logicValue = rnData | opB;
      opMov:        logicValue = opB;
      opBic:        logicValue = rnData & ~opB;
      opMvn:        logicValue = ~opB;
      opSub, opCmp:
      begin
        addA    = rnData;
        addB    = ~opB;
        addCin  = 1'b1;
        isArith = 1'b1;
      end
      opRsb:
      begin
        addA    = opB;
        addB    = ~rnData;
        addCin  = 1'b1;
        isArith = 1'b1;
      end
      opAdd, opCmn:
      begin
        addA    = rnData;
        addB    = opB;
        isArith = 1'b1;
      end
      opAdc:
      begin
        addA    = rnData;
        addB    = opB;
        addCin  = flagsQ.c;
        isArith = 1'b1;
      end
      opSbc:
      begin
        addA    = rnData;
        addB    = ~opB;
        addCin  = flagsQ.c;
        isArith = 1'b1;
      end
      opRsc:
      begin
        addA    = opB;
        addB    = ~rnData;
        addCin  = flagsQ.c;
        isArith = 1'b1;
      end
      default:      logicValue = '0;
    endcase
  end

  assign sum      = {1'b0, addA} + {1'b0, addB} + {{`ARMDP_DATA_W{1'b0}}, addCin};
  assign carryOut = sum[`ARMDP_DATA_W];
  // Same-sign inputs giving an opposite-sign sum
  assign overflow = (addA[Msb] == addB[Msb]) && (sum[Msb] != addA[Msb]);
  assign aluValue = isArith ? sum[Msb:0] : logicValue;

  assign isTest = opcode inside {opTst, opTeq, opCmp, opCmn};

  // Logical ops leave C and V alone
  always_comb
  begin
    flagsNext.n = aluValue[Msb];
    flagsNext.z = (aluValue == '0);
    flagsNext.c = isArith ? carryOut : flagsQ.c;
    flagsNext.v = isArith ? overflow : flagsQ.v;
  end

  assign rfWrite.en   = instrValid && !isTest;
  assign rfWrite.addr = rd;
  assign rfWrite.data = aluValue;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      flagsQ <= '0;
      validQ <= 1'b0;
      wroteQ <= 1'b0;
    end
    else
    begin
      validQ <= instrValid;
      if (instrValid)
      begin
        wroteQ <= !isTest;
        if (instr.immForm.setFlags)
        begin
          flagsQ <= flagsNext;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (instrValid)
    begin
      rdQ   <= rd;
      dataQ <= aluValue;
    end
  end

  assign resultValid  = validQ;
  assign result.wrote = wroteQ;
  assign result.rd    = rdQ;
  assign result.data  = dataQ;
  assign flags        = flagsQ;

endmodule

/* hw/immRotator.sv */
`timescale 1ns/1ps
`include "armDp_defines.svh"

module immRotator (
  input  logic [3:0]      rotate,
  input  logic [7:0]      imm8,
  output armDpPkg::word_t immOperand
);

  import armDpPkg::*;

  word_t                      immExt;
  logic [4:0]                 rotAmt;
  logic [2*`ARMDP_DATA_W-1:0] immDouble;
  logic [2*`ARMDP_DATA_W-1:0] immShifted;

  assign immExt = {{(`ARMDP_DATA_W-8){1'b0}}, imm8};

  // Rotation is always by an even amount
  assign rotAmt = {rotate, 1'b0};

  // Right shift of the doubled word gives a rotate
  assign immDouble  = {immExt, immExt};
  assign immShifted = immDouble >> rotAmt;

  assign immOperand = immShifted[`ARMDP_DATA_W-1:0];

endmodule

/* regFile/regFile.sv */
`timescale 1ns/1ps
`include "armDp_defines.svh"

module regFile (
  input  logic               clk,
  input  logic               rstN,
  input  armDpPkg::regIdx_t  rnAddr,
  input  armDpPkg::regIdx_t  rmAddr,
  input  armDpPkg::rfWrite_s write,
  output armDpPkg::word_t    rnData,
  output armDpPkg::word_t    rmData
);

  import armDpPkg::*;

  word_t regs [`ARMDP_REG_CNT];

  // Single write port, all entries cleared on reset
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `ARMDP_REG_CNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (write.en)
    begin
      regs[write.addr] <= write.data;
    end
  end

  // No bypass, a write shows up after its edge
  assign rnData = regs[rnAddr];
  assign rmData = regs[rmAddr];

endmodule

/* common/armDpPkg.sv */
`include "armDp_defines.svh"

package armDpPkg;

  typedef logic [`ARMDP_DATA_W-1:0] word_t;
  typedef logic [`ARMDP_REG_IDX_W-1:0] regIdx_t;

  typedef enum logic [`ARMDP_OPC_W-1:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opRsb = 4'd3,
    opAdd = 4'd4,
    opAdc = 4'd5,
    opSbc = 4'd6,
    opRsc = 4'd7,
    opTst = 4'd8,
    opTeq = 4'd9,
    opCmp = 4'd10,
    opCmn = 4'd11,
    opOrr = 4'd12,
    opMov = 4'd13,
    opBic = 4'd14,
    opMvn = 4'd15
  } aluOp_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_s;

  // Immediate form, operand 2 is a rotated imm8
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] cls;
    logic       immSel;
    aluOp_e     opcode;
    logic       setFlags;
    regIdx_t    rn;
    regIdx_t    rd;
    logic [3:0] rotate;
    logic [7:0] imm8;
  } immForm_s;

  // Register form, shift field is not decoded
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] cls;
    logic       immSel;
    aluOp_e     opcode;
    logic       setFlags;
    regIdx_t    rn;
    regIdx_t    rd;
    logic [7:0] shiftField;
    regIdx_t    rm;
  } regForm_s;

  typedef union packed {
    immForm_s immForm;
    regForm_s regForm;
  } dpInstr_u;

  typedef struct packed {
    logic    en;
    regIdx_t addr;
    word_t   data;
  } rfWrite_s;

  typedef struct packed {
    logic    wrote;
    regIdx_t rd;
    word_t   data;
  } dpResult_s;

endpackage

/* common/armDp_defines.svh */
`ifndef ARMDP_DEFINES_SVH
`define ARMDP_DEFINES_SVH

// Datapath word width
`define ARMDP_DATA_W 32

// Register file depth and index width
`define ARMDP_REG_CNT 16
`define ARMDP_REG_IDX_W 4

// Data-processing opcode field width
`define ARMDP_OPC_W 4

`endif
